// File: files.f
+incdir+include
hw/ecc_pkg.sv
hw/hsiao_ecc_enc.sv
hw/hsiao_ecc_dec.sv
hw/hci_ecc_dec.sv
hw/tcdm_bank.sv
hw/ecc_tcdm_top.sv
verif/tb_clk_gen.sv
verif/tb_ecc_tcdm.sv

// File: run.sh
#!/bin/sh
# build and run the ECC TCDM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f files.f --top-module tb_ecc_tcdm -Mdir build

./build/Vtb_ecc_tcdm > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: verif/tb_ecc_tcdm.sv
`include "ecc_macros.svh"

module tb_ecc_tcdm;

  timeunit 1ns;
  timeprecision 100ps;

  import ecc_pkg::*;

  localparam int MW = `ECC_RQMETAW;
  localparam int MK = `ECC_EW_RQMETA;
  localparam int CW = `ECC_CHUNK;
  localparam int CK = `ECC_EW_DW;
  localparam int RW = `ECC_RSMETAW;
  localparam int RK = `ECC_EW_RSMETA;
  localparam int TimeoutCycles = 600;

  typedef struct packed {
    logic [63:0] data;
    logic [7:0]  syn;
    logic        single;
    logic        multi;
  } dec_t;

  typedef struct packed {
    logic [1:0] dsingle;
    logic [1:0] dmulti;
    logic       msingle;
    logic       mmulti;
    tcdm_rsp_t  rsp;
  } exp_t;

  logic                   clk;
  logic                   rst_n;
  logic                   req;
  logic                   gnt;
  tcdm_req_t              req_data;
  ecc_t                   req_ecc;
  logic                   rsp_valid;
  tcdm_rsp_t              rsp;
  ecc_t                   rsp_ecc;
  logic [`ECC_NCHUNK-1:0] data_single;
  logic [`ECC_NCHUNK-1:0] data_multi;
  logic                   meta_single;
  logic                   meta_multi;

  data_t shadow [`ECC_DEPTH];
  exp_t  exp_q [$];
  logic  rsp_pending = 1'b0;
  int    value_errs = 0;
  int    proto_errs = 0;

  tb_clk_gen #(.ResetCycles(3)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  ecc_tcdm_top i_dut (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (req), .gnt_o (gnt),
    .req_data_i (req_data), .req_ecc_i (req_ecc),
    .rsp_valid_o (rsp_valid), .rsp_o (rsp), .rsp_ecc_o (rsp_ecc),
    .data_single_err_o (data_single), .data_multi_err_o (data_multi),
    .meta_single_err_o (meta_single), .meta_multi_err_o (meta_multi)
  );

  // odd-weight k-bit columns of weight 3 and up, by weight then value
  function automatic logic [7:0] col_ref(int k, int idx);
    int n;
    n = 0;
    for (int w = 3; w <= k; w += 2) begin
      for (int v = 0; v < (1 << k); v++) begin
        if ($countones(v) == w) begin
          if (n == idx) return 8'(v);
          n++;
        end
      end
    end
    return 8'h00;
  endfunction

  function automatic logic [7:0] hsiao_ref_enc(logic [63:0] data, int width, int k);
    logic [7:0] chk;
    chk = '0;
    for (int i = 0; i < width; i++) begin
      if (data[i]) chk ^= col_ref(k, i);
    end
    return chk;
  endfunction

  function automatic dec_t hsiao_ref_dec(logic [63:0] data, logic [7:0] chk, int width, int k);
    dec_t r;
    r = '0;
    r.data = data;
    r.syn = hsiao_ref_enc(data, width, k) ^ chk;
    for (int i = 0; i < width; i++) begin
      if (r.syn != 0 && col_ref(k, i) == r.syn) begin
        r.data[i] = ~data[i];
        r.single = 1'b1;
      end
    end
    // weight one points at a check bit
    if ($countones(r.syn) == 1) r.single = 1'b1;
    r.multi = (r.syn != 0) && !r.single;
    return r;
  endfunction

  task automatic compare_val(string name, logic [63:0] exp_v, logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      $display("FAIL %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
      value_errs++;
    end
  endtask

  task automatic expect_protocol(logic ok, string what);
    assert (ok) else begin
      $display("protocol error at %0t: %s", $time, what);
      proto_errs++;
    end
  endtask

  task automatic drive_idle(int n);
    repeat (n) begin
      @(posedge clk);
      req <= 1'b0;
    end
  endtask

  // domain 0 is metadata, 1 and 2 are the data chunks
  task automatic send_req(logic wen, addr_t add, int domain, int nflip);
    logic [MW-1:0]    meta;
    logic [MK+MW-1:0] cw_m;
    logic [CK+CW-1:0] cw0;
    logic [CK+CW-1:0] cw1;
    logic [63:0]      mask;
    logic [7:0]       chk;
    data_t            wdata;
    tcdm_req_t        rq;
    dec_t             dm;
    dec_t             d0;
    dec_t             d1;
    exp_t             e;
    int               width;
    int               p1;
    int               p2;
    addr_t            dadd;
    logic             dwen;
    be_t              dbe;
    user_t            duser;
    data_t            ddata;
    wdata = {$urandom, $urandom};
    meta = {add, wen, be_t'($urandom), user_t'($urandom)};
    chk = hsiao_ref_enc(64'(meta), MW, MK);
    cw_m = {chk[MK-1:0], meta};
    chk = hsiao_ref_enc(64'(wdata[31:0]), CW, CK);
    cw0 = {chk[CK-1:0], wdata[31:0]};
    chk = hsiao_ref_enc(64'(wdata[63:32]), CW, CK);
    cw1 = {chk[CK-1:0], wdata[63:32]};
    // two distinct bit positions within the chosen codeword
    width = (domain == 0) ? MK + MW : CK + CW;
    p1 = int'($urandom % width);
    p2 = (p1 + 1 + int'($urandom % (width - 1))) % width;
    mask = '0;
    if (nflip > 0) mask[p1] = 1'b1;
    if (nflip > 1) mask[p2] = 1'b1;
    case (domain)
      0: cw_m ^= mask[MK+MW-1:0];
      1: cw0 ^= mask[CK+CW-1:0];
      default: cw1 ^= mask[CK+CW-1:0];
    endcase
    dm = hsiao_ref_dec(64'(cw_m[MW-1:0]), 8'(cw_m[MW +: MK]), MW, MK);
    d0 = hsiao_ref_dec(64'(cw0[CW-1:0]), 8'(cw0[CW +: CK]), CW, CK);
    d1 = hsiao_ref_dec(64'(cw1[CW-1:0]), 8'(cw1[CW +: CK]), CW, CK);
    {dadd, dwen, dbe, duser} = dm.data[MW-1:0];
    ddata = {d1.data[CW-1:0], d0.data[CW-1:0]};
    e = '0;
    e.dsingle = {d1.single, d0.single};
    e.dmulti = {d1.multi, d0.multi};
    e.msingle = dm.single;
    e.mmulti = dm.multi;
    e.rsp.r_opc = dm.multi | d0.multi | d1.multi;
    e.rsp.r_user = duser;
    // word index is add[8:3]
    e.rsp.r_data = (dwen && !e.rsp.r_opc) ? shadow[dadd[8:3]] : '0;
    if (!dwen && !e.rsp.r_opc) begin
      for (int b = 0; b < `ECC_BW; b++) begin
        if (dbe[b]) shadow[dadd[8:3]][8*b +: 8] = ddata[8*b +: 8];
      end
    end
    {rq.add, rq.wen, rq.be, rq.user} = cw_m[MW-1:0];
    rq.data = {cw1[CW-1:0], cw0[CW-1:0]};
    @(posedge clk);
    req <= 1'b1;
    req_data <= rq;
    req_ecc <= {cw1[CW +: CK], cw0[CW +: CK], cw_m[MW +: MK]};
    exp_q.push_back(e);
  endtask

  // scoreboard, sampled on the falling edge
  initial begin : scoreboard
    exp_t          cur;
    exp_t          pend;
    logic [RW-1:0] rmeta;
    logic [7:0]    c0;
    logic [7:0]    c1;
    logic [7:0]    cm;
    dec_t          r0;
    dec_t          r1;
    dec_t          rm;
    pend = '0;
    @(posedge clk);
    forever begin
      @(negedge clk);
      if (rsp_pending) begin
        expect_protocol(rsp_valid === 1'b1, "no response one cycle after a request");
        compare_val("rsp_o.r_data", pend.rsp.r_data, rsp.r_data);
        compare_val("rsp_o.r_opc", 64'(pend.rsp.r_opc), 64'(rsp.r_opc));
        compare_val("rsp_o.r_user", 64'(pend.rsp.r_user), 64'(rsp.r_user));
        // check bits of the expected response
        rmeta = {pend.rsp.r_opc, pend.rsp.r_user};
        c0 = hsiao_ref_enc(64'(pend.rsp.r_data[31:0]), CW, CK);
        c1 = hsiao_ref_enc(64'(pend.rsp.r_data[63:32]), CW, CK);
        cm = hsiao_ref_enc(64'(rmeta), RW, RK);
        compare_val("rsp_ecc_o", 64'({2'b00, c1[CK-1:0], c0[CK-1:0], cm[RK-1:0]}),
                    64'(rsp_ecc));
      end else begin
        expect_protocol(rsp_valid === 1'b0, "response without a request in the previous cycle");
      end
      if (rsp_valid === 1'b1) begin
        rmeta = {rsp.r_opc, rsp.r_user};
        r0 = hsiao_ref_dec(64'(rsp.r_data[31:0]), 8'(rsp_ecc[RK +: CK]), CW, CK);
        r1 = hsiao_ref_dec(64'(rsp.r_data[63:32]), 8'(rsp_ecc[RK+CK +: CK]), CW, CK);
        rm = hsiao_ref_dec(64'(rmeta), 8'(rsp_ecc[RK-1:0]), RW, RK);
        compare_val("rsp_ecc_o syndromes", 64'h0, 64'({r1.syn, r0.syn, rm.syn}));
      end
      rsp_pending = 1'b0;
      cur = '0;
      if (req === 1'b1) begin
        expect_protocol(exp_q.size() != 0, "request with no expected entry");
        if (exp_q.size() != 0) begin
          cur = exp_q.pop_front();
          pend = cur;
          rsp_pending = 1'b1;
        end
      end
      compare_val("gnt_o", 64'(req), 64'(gnt));
      compare_val("data_single_err_o", 64'(cur.dsingle), 64'(data_single));
      compare_val("data_multi_err_o", 64'(cur.dmulti), 64'(data_multi));
      compare_val("meta_single_err_o", 64'(cur.msingle), 64'(meta_single));
      compare_val("meta_multi_err_o", 64'(cur.mmulti), 64'(meta_multi));
    end
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the run did not complete", cycle_cnt);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    addr_t addrs [64];
    void'($urandom(22148));
    req = 1'b0;
    req_data = '0;
    req_ecc = '0;
    for (int w = 0; w < `ECC_DEPTH; w++) begin
      shadow[w] = '0;
    end
    @(posedge rst_n);
    // clean writes, then read back
    for (int i = 0; i < 64; i++) begin
      addrs[i] = addr_t'($urandom);
      send_req(1'b0, addrs[i], 0, 0);
    end
    for (int i = 0; i < 64; i++) begin
      send_req(1'b1, addrs[i], 0, 0);
    end
    drive_idle(3);
    // single flips in a chunk or its check bits
    for (int i = 0; i < 80; i++) begin
      send_req(1'($urandom), addrs[$urandom % 64], 1 + int'($urandom % 2), 1);
    end
    drive_idle(3);
    // single flips in the metadata
    for (int i = 0; i < 80; i++) begin
      send_req(1'($urandom), addrs[$urandom % 64], 0, 1);
    end
    drive_idle(3);
    // double flips, mostly writes, then clean reads of the same words
    for (int i = 0; i < 50; i++) begin
      send_req(($urandom % 4) == 0, addrs[i], int'($urandom % 3), 2);
    end
    drive_idle(2);
    for (int i = 0; i < 50; i++) begin
      send_req(1'b1, addrs[i], 0, 0);
    end
    drive_idle(1);
    while (exp_q.size() != 0 || rsp_pending) begin
      @(posedge clk);
    end
    drive_idle(2);
    $display("value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // release on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: hw/ecc_tcdm_top.sv
`include "ecc_macros.svh"

module ecc_tcdm_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  output logic                   gnt_o,
  input  ecc_pkg::tcdm_req_t     req_data_i,
  input  ecc_pkg::ecc_t          req_ecc_i,
  output logic                   rsp_valid_o,
  output ecc_pkg::tcdm_rsp_t     rsp_o,
  output ecc_pkg::ecc_t          rsp_ecc_o,
  output logic [`ECC_NCHUNK-1:0] data_single_err_o,
  output logic [`ECC_NCHUNK-1:0] data_multi_err_o,
  output logic                   meta_single_err_o,
  output logic                   meta_multi_err_o
);

  import ecc_pkg::*;

  // decoder to bank
  tcdm_req_t bank_req;
  logic      bank_req_valid;
  logic      bank_req_uncorr;
  logic      bank_gnt;
  tcdm_rsp_t bank_rsp;
  logic      bank_rsp_valid;

  hci_ecc_dec #(
    .EnableData ( 1'b1 )
  ) i_ecc_dec (
    .req_i             ( req_i             ),
    .req_data_i        ( req_data_i        ),
    .req_ecc_i         ( req_ecc_i         ),
    .gnt_o             ( gnt_o             ),
    .bank_req_valid_o  ( bank_req_valid    ),
    .bank_req_o        ( bank_req          ),
    .bank_req_uncorr_o ( bank_req_uncorr   ),
    .bank_gnt_i        ( bank_gnt          ),
    .bank_rsp_i        ( bank_rsp          ),
    .bank_rsp_valid_i  ( bank_rsp_valid    ),
    .rsp_o             ( rsp_o             ),
    .rsp_ecc_o         ( rsp_ecc_o         ),
    .rsp_valid_o       ( rsp_valid_o       ),
    .data_single_err_o ( data_single_err_o ),
    .data_multi_err_o  ( data_multi_err_o  ),
    .meta_single_err_o ( meta_single_err_o ),
    .meta_multi_err_o  ( meta_multi_err_o  )
  );

  tcdm_bank i_bank (
    .clk_i       ( clk_i           ),
    .rst_n_i     ( rst_n_i         ),
    .req_i       ( bank_req_valid  ),
    .req_data_i  ( bank_req        ),
    .uncorr_i    ( bank_req_uncorr ),
    .gnt_o       ( bank_gnt        ),
    .rsp_valid_o ( bank_rsp_valid  ),
    .rsp_o       ( bank_rsp        )
  );

endmodule

// File: hw/tcdm_bank.sv
`include "ecc_macros.svh"

module tcdm_bank (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  ecc_pkg::tcdm_req_t req_data_i,
  input  logic               uncorr_i,
  output logic               gnt_o,
  output logic               rsp_valid_o,
  output ecc_pkg::tcdm_rsp_t rsp_o
);

  import ecc_pkg::*;

  localparam int unsigned IdxW  = $clog2(`ECC_DEPTH);
  localparam int unsigned OffW  = $clog2(`ECC_BW);
  localparam int unsigned ByteW = `ECC_DW / `ECC_BW;

  typedef logic [IdxW-1:0] idx_t;

  data_t     mem_q [`ECC_DEPTH];
  idx_t      idx;
  logic      req_gnt;
  logic      wr_en;
  logic      rd_ok;
  logic      rsp_valid_q;
  tcdm_rsp_t rsp_q;

  // always ready
  assign gnt_o   = req_i;
  assign req_gnt = req_i & gnt_o;

  // word index, byte offset dropped
  assign idx   = req_data_i.add[OffW +: IdxW];
  assign wr_en = req_gnt & ~req_data_i.wen & ~uncorr_i;
  assign rd_ok = req_data_i.wen & ~uncorr_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned w = 0; w < `ECC_DEPTH; w++) begin
        mem_q[w] <= '0;
      end
    end else if (wr_en) begin
      for (int unsigned b = 0; b < `ECC_BW; b++) begin
        if (req_data_i.be[b]) begin
          mem_q[idx][ByteW*b +: ByteW] <= req_data_i.data[ByteW*b +: ByteW];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_gnt;
    end
  end

  // writes and uncorrectable requests answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_gnt) begin
      rsp_q.r_data <= rd_ok ? mem_q[idx] : '0;
      rsp_q.r_opc  <= uncorr_i;
      rsp_q.r_user <= req_data_i.user;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

  // response only one cycle after a grant
  a_rsp_after_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o |-> $past(req_gnt)
  );

endmodule

// File: hw/hci_ecc_dec.sv
`include "ecc_macros.svh"

module hci_ecc_dec #(
  parameter bit EnableData = 1'b1
) (
  // protected request from the initiator
  input  logic                    req_i,
  input  ecc_pkg::tcdm_req_t      req_data_i,
  input  ecc_pkg::ecc_t           req_ecc_i,
  output logic                    gnt_o,
  // corrected request to the bank
  output logic                    bank_req_valid_o,
  output ecc_pkg::tcdm_req_t      bank_req_o,
  output logic                    bank_req_uncorr_o,
  input  logic                    bank_gnt_i,
  // response path
  input  ecc_pkg::tcdm_rsp_t      bank_rsp_i,
  input  logic                    bank_rsp_valid_i,
  output ecc_pkg::tcdm_rsp_t      rsp_o,
  output ecc_pkg::ecc_t           rsp_ecc_o,
  output logic                    rsp_valid_o,
  // error strobes
  output logic [`ECC_NCHUNK-1:0]  data_single_err_o,
  output logic [`ECC_NCHUNK-1:0]  data_multi_err_o,
  output logic                    meta_single_err_o,
  output logic                    meta_multi_err_o
);

  import ecc_pkg::*;

  localparam int unsigned ZeroBits = `ECC_EW - `ECC_NCHUNK*`ECC_EW_DW - `ECC_EW_RSMETA;

  addr_t                                    add_c;
  logic                                     wen_c;
  be_t                                      be_c;
  user_t                                    user_c;
  chunk_t [`ECC_NCHUNK-1:0]                 data_c;
  logic   [`ECC_NCHUNK-1:0]                 data_single;
  logic   [`ECC_NCHUNK-1:0]                 data_multi;
  logic   [1:0]                             meta_err;
  logic   [`ECC_NCHUNK-1:0][`ECC_EW_DW-1:0] r_data_ecc;
  logic   [`ECC_EW_RSMETA+`ECC_RSMETAW-1:0] r_meta_enc;

  // request metadata, add/wen/be/user from msb down
  hsiao_ecc_dec #(
    .DataWidth ( `ECC_RQMETAW   ),
    .ProtWidth ( `ECC_EW_RQMETA )
  ) i_meta_dec (
    .in_i       ( {req_ecc_i[`ECC_EW_RQMETA-1:0], req_data_i.add, req_data_i.wen,
                   req_data_i.be, req_data_i.user} ),
    .out_o      ( {add_c, wen_c, be_c, user_c} ),
    .syndrome_o (  ),
    .err_o      ( meta_err )
  );

  if (EnableData) begin : gen_data_dec
    for (genvar ii = 0; ii < `ECC_NCHUNK; ii++) begin : gen_chunk
      logic [1:0] chunk_err;

      hsiao_ecc_dec #(
        .DataWidth ( `ECC_CHUNK  ),
        .ProtWidth ( `ECC_EW_DW  )
      ) i_data_dec (
        .in_i       ( {req_ecc_i[`ECC_EW_RQMETA + ii*`ECC_EW_DW +: `ECC_EW_DW],
                       req_data_i.data[ii*`ECC_CHUNK +: `ECC_CHUNK]} ),
        .out_o      ( data_c[ii] ),
        .syndrome_o (  ),
        .err_o      ( chunk_err )
      );

      assign data_single[ii] = chunk_err[0];
      assign data_multi[ii]  = chunk_err[1];
    end
  end else begin : gen_no_data_dec
    // data unchecked
    assign data_c      = req_data_i.data;
    assign data_single = '0;
    assign data_multi  = '0;
  end

  assign bank_req_o = '{
    add:  add_c,
    wen:  wen_c,
    be:   be_c,
    data: data_c,
    user: user_c
  };

  // strobes only mean something during a request
  assign data_single_err_o = req_i ? data_single : '0;
  assign data_multi_err_o  = req_i ? data_multi  : '0;
  assign meta_single_err_o = req_i & meta_err[0];
  assign meta_multi_err_o  = req_i & meta_err[1];

  assign bank_req_uncorr_o = meta_multi_err_o | (|data_multi_err_o);
  assign bank_req_valid_o  = req_i;
  assign gnt_o             = bank_gnt_i;

  // response encoding
  if (EnableData) begin : gen_data_enc
    for (genvar ii = 0; ii < `ECC_NCHUNK; ii++) begin : gen_chunk
      logic [`ECC_EW_DW+`ECC_CHUNK-1:0] r_data_enc;

      hsiao_ecc_enc #(
        .DataWidth ( `ECC_CHUNK ),
        .ProtWidth ( `ECC_EW_DW )
      ) i_data_enc (
        .in_i  ( bank_rsp_i.r_data[ii*`ECC_CHUNK +: `ECC_CHUNK] ),
        .out_o ( r_data_enc )
      );

      assign r_data_ecc[ii] = r_data_enc[`ECC_CHUNK +: `ECC_EW_DW];
    end
  end else begin : gen_no_data_enc
    assign r_data_ecc = '0;
  end

  hsiao_ecc_enc #(
    .DataWidth ( `ECC_RSMETAW   ),
    .ProtWidth ( `ECC_EW_RSMETA )
  ) i_meta_enc (
    .in_i  ( {bank_rsp_i.r_opc, bank_rsp_i.r_user} ),
    .out_o ( r_meta_enc )
  );

  assign rsp_o       = bank_rsp_i;
  assign rsp_valid_o = bank_rsp_valid_i;
  assign rsp_ecc_o   = {{ZeroBits{1'b0}}, r_data_ecc, r_meta_enc[`ECC_RSMETAW +: `ECC_EW_RSMETA]};

  // no strobe without a request
  always_comb begin
    a_strobe_gate: assert final (
      req_i || !(|{data_single_err_o, data_multi_err_o, meta_single_err_o,
                   meta_multi_err_o})
    );
  end

endmodule

// File: hw/hsiao_ecc_dec.sv
module hsiao_ecc_dec #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [ProtWidth+DataWidth-1:0] in_i,
  output logic [DataWidth-1:0]           out_o,
  output logic [ProtWidth-1:0]           syndrome_o,
  output logic [1:0]                     err_o
);

  import ecc_pkg::*;

  logic [DataWidth-1:0]                data;
  logic [ProtWidth-1:0]                chk_rx;
  logic [ProtWidth-1:0][DataWidth-1:0] sel;
  logic [ProtWidth-1:0]                chk_calc;
  logic [ProtWidth-1:0]                syndrome;
  logic [DataWidth-1:0]                flip;
  logic                                chk_bit_err;
  logic                                single_err;
  logic                                multi_err;

  assign data   = in_i[DataWidth-1:0];
  assign chk_rx = in_i[DataWidth +: ProtWidth];

  for (genvar i = 0; i < DataWidth; i++) begin : gen_col
    localparam logic [ProtWidth-1:0] Col = ProtWidth'(hsiao_col(ProtWidth, i));

    for (genvar j = 0; j < ProtWidth; j++) begin : gen_row
      assign sel[j][i] = Col[j] & data[i];
    end

    // syndrome points at this data bit
    assign flip[i] = (syndrome == Col);
  end

  for (genvar j = 0; j < ProtWidth; j++) begin : gen_chk
    assign chk_calc[j] = ^sel[j];
  end

  assign syndrome = chk_calc ^ chk_rx;

  // weight one means a flipped check bit, data stays as is
  assign chk_bit_err = ($countones(syndrome) == 1);
  assign single_err  = (|flip) | chk_bit_err;
  // even weight or an odd pattern that is no column
  assign multi_err   = (|syndrome) & ~single_err;

  assign out_o      = data ^ flip;
  assign syndrome_o = syndrome;
  assign err_o      = {multi_err, single_err};

  // at most one data bit is corrected, and only on a single error
  always_comb begin
    a_err_class: assert final (
      !(err_o[0] && err_o[1]) &&
      ($countones(out_o ^ data) <= (err_o[0] ? 1 : 0))
    );
  end

endmodule

// File: hw/hsiao_ecc_enc.sv
module hsiao_ecc_enc #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7
) (
  input  logic [DataWidth-1:0]           in_i,
  output logic [ProtWidth+DataWidth-1:0] out_o
);

  import ecc_pkg::*;

  // sel[j][i] is data bit i if its column covers check bit j
  logic [ProtWidth-1:0][DataWidth-1:0] sel;
  logic [ProtWidth-1:0]                chk;

  for (genvar i = 0; i < DataWidth; i++) begin : gen_col
    localparam logic [ProtWidth-1:0] Col = ProtWidth'(hsiao_col(ProtWidth, i));

    for (genvar j = 0; j < ProtWidth; j++) begin : gen_row
      assign sel[j][i] = Col[j] & in_i[i];
    end
  end

  // one parity tree per check bit
  for (genvar j = 0; j < ProtWidth; j++) begin : gen_chk
    assign chk[j] = ^sel[j];
  end

  // check bits on top, data passes below
  assign out_o = {chk, in_i};

endmodule

// File: hw/ecc_pkg.sv
`include "ecc_macros.svh"

package ecc_pkg;

  typedef logic [`ECC_DW-1:0]    data_t;
  typedef logic [`ECC_CHUNK-1:0] chunk_t;
  typedef logic [`ECC_AW-1:0]    addr_t;
  typedef logic [`ECC_BW-1:0]    be_t;
  typedef logic [`ECC_UW-1:0]    user_t;
  typedef logic [`ECC_EW-1:0]    ecc_t;

  // wen high means read
  typedef struct packed {
    addr_t add;
    logic  wen;
    be_t   be;
    data_t data;
    user_t user;
  } tcdm_req_t;

  typedef struct packed {
    data_t r_data;
    logic  r_opc;
    user_t r_user;
  } tcdm_rsp_t;

  // idx-th odd-weight column (weight >= 3) for k check bits, k up to 8
  // ordered by weight first, then by value
  function automatic logic [7:0] hsiao_col(int unsigned k, int unsigned idx);
    logic [7:0]  col;
    int unsigned n;
    col = '0;
    n   = 0;
    for (int unsigned w = 3; w <= k; w += 2) begin
      for (int unsigned v = 0; v < (1 << k); v++) begin
        if ($countones(v) == w) begin
          if (n == idx) begin
            col = v[7:0];
          end
          n++;
        end
      end
    end
    return col;
  endfunction

endpackage

// File: include/ecc_macros.svh
`ifndef ECC_MACROS_SVH
`define ECC_MACROS_SVH

// data path widths
`define ECC_DW         64
`define ECC_CHUNK      32
`define ECC_NCHUNK     2

// request fields
`define ECC_AW         9
`define ECC_BW         8
`define ECC_UW         4

// check bits per protected field
`define ECC_EW_DW      7
`define ECC_RQMETAW    22
`define ECC_EW_RQMETA  7
`define ECC_RSMETAW    5
`define ECC_EW_RSMETA  5
`define ECC_EW         21

// bank size in 64-bit words
`define ECC_DEPTH      64

`endif
